// File: logic/cpu_pkg.sv
package cpu_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [31:0]           inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [4:0]            alu_op_t;
    typedef logic [1:0]            alu_sel_t;

    localparam word_t ZERO_WORD = '0;

    // Major opcodes of the register and immediate integer groups.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000; // Also marks SRA, which is not supported.

    localparam alu_op_t EXE_NOP_OP   = 5'd0;
    localparam alu_op_t EXE_OR_OP    = 5'd1;
    localparam alu_op_t EXE_AND_OP   = 5'd2;
    localparam alu_op_t EXE_XOR_OP   = 5'd3;
    localparam alu_op_t EXE_ORI_OP   = 5'd4;
    localparam alu_op_t EXE_ANDI_OP  = 5'd5;
    localparam alu_op_t EXE_XORI_OP  = 5'd6;
    localparam alu_op_t EXE_SLL_OP   = 5'd7;
    localparam alu_op_t EXE_SLLI_OP  = 5'd8;
    localparam alu_op_t EXE_SRL_OP   = 5'd9;
    localparam alu_op_t EXE_SRLI_OP  = 5'd10;
    localparam alu_op_t EXE_SLT_OP   = 5'd11;
    localparam alu_op_t EXE_SLTI_OP  = 5'd12;
    localparam alu_op_t EXE_SLTU_OP  = 5'd13;
    localparam alu_op_t EXE_SLTIU_OP = 5'd14;
    localparam alu_op_t EXE_ADD_OP   = 5'd15;
    localparam alu_op_t EXE_ADDI_OP  = 5'd16;
    localparam alu_op_t EXE_SUB_OP   = 5'd17;

    // Compares share the arithmetic result path.
    localparam alu_sel_t EXE_RES_NOP   = 2'b00;
    localparam alu_sel_t EXE_RES_LOGIC = 2'b01;
    localparam alu_sel_t EXE_RES_SHIFT = 2'b10;
    localparam alu_sel_t EXE_RES_ARITH = 2'b11;

endpackage

// File: logic/exec_if.sv
`timescale 1ns/10ps

interface exec_if;
    import cpu_pkg::*;

    logic      valid;
    logic      ready;
    alu_op_t   aluop;
    alu_sel_t  alusel;
    word_t     reg1;
    word_t     reg2;
    reg_addr_t shamt;
    word_t     imm;
    reg_addr_t rd;
    logic      wreg;

    modport decode_mp (
        output valid, aluop, alusel, reg1, reg2, shamt, imm, rd, wreg,
        input  ready
    );

    modport ex_mp (
        input  valid, aluop, alusel, reg1, reg2, shamt, imm, rd, wreg,
        output ready
    );

endinterface

// File: logic/inst_port.sv
`timescale 1ns/10ps

module inst_port (
    input  logic           clk_i,
    input  logic           arst_n_i,
    input  logic           inst_req_i,
    input  cpu_pkg::inst_t inst_i,
    output logic           inst_ack_o,
    output logic           inst_valid_o,
    output cpu_pkg::inst_t inst_o,
    input  logic           inst_ready_i
);

    typedef enum logic [1:0] {
        IDLE,
        ACK,
        WAIT_LOW
    } state_e;

    state_e state_q;
    logic   has_space;

    // The buffer can take a word if it is empty or drained in this cycle.
    assign has_space  = !inst_valid_o || inst_ready_i;
    assign inst_ack_o = (state_q == ACK);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q      <= WAIT_LOW; // A request left high across reset is not taken.
            inst_valid_o <= 1'b0;
            inst_o       <= '0;
        end else begin
            if (inst_ready_i) begin
                inst_valid_o <= 1'b0;
            end
            case (state_q)
                WAIT_LOW: if (!inst_req_i) state_q <= IDLE;
                IDLE: begin
                    if (inst_req_i && has_space) begin
                        state_q      <= ACK;
                        inst_valid_o <= 1'b1;
                        inst_o       <= inst_i;
                    end
                end
                ACK: if (!inst_req_i) state_q <= IDLE; // Ack falls one cycle after req.
                default: state_q <= WAIT_LOW;
            endcase
        end
    end

endmodule

// File: logic/decode.sv
`timescale 1ns/10ps

module decode (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               inst_valid_i,
    input  cpu_pkg::inst_t     inst_i,
    output logic               inst_ready_o,
    output cpu_pkg::reg_addr_t rs1_addr_o,
    output cpu_pkg::reg_addr_t rs2_addr_o,
    input  cpu_pkg::word_t     rs1_data_i,
    input  cpu_pkg::word_t     rs2_data_i,
    input  logic               fwd_valid_i,
    input  logic               fwd_wreg_i,
    input  cpu_pkg::reg_addr_t fwd_rd_i,
    input  cpu_pkg::word_t     fwd_data_i,
    exec_if.decode_mp          ex_o
);
    import cpu_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    reg_addr_t  shamt;
    word_t      imm;
    alu_op_t    aluop;
    alu_sel_t   alusel;
    word_t      reg1;
    word_t      reg2;
    logic       hazard;
    logic       load;

    assign opcode     = inst_i[6:0];
    assign rd         = inst_i[11:7];
    assign funct3     = inst_i[14:12];
    assign rs1        = inst_i[19:15];
    assign rs2        = inst_i[24:20];
    assign funct7     = inst_i[31:25];
    assign shamt      = inst_i[24:20];
    assign imm        = {{20{inst_i[31]}}, inst_i[31:20]};
    assign rs1_addr_o = rs1;
    assign rs2_addr_o = rs2;

    always_comb begin
        aluop = EXE_NOP_OP;
        case (opcode)
            OPC_OP: begin
                if (funct7 == F7_SUB) begin
                    if (funct3 == F3_ADD_SUB) aluop = EXE_SUB_OP;
                end else if (funct7 == F7_BASE) begin
                    case (funct3)
                        F3_ADD_SUB: aluop = EXE_ADD_OP;
                        F3_SLL:     aluop = EXE_SLL_OP;
                        F3_SLT:     aluop = EXE_SLT_OP;
                        F3_SLTU:    aluop = EXE_SLTU_OP;
                        F3_XOR:     aluop = EXE_XOR_OP;
                        F3_SRL:     aluop = EXE_SRL_OP;
                        F3_OR:      aluop = EXE_OR_OP;
                        default:    aluop = EXE_AND_OP;
                    endcase
                end
            end
            OPC_OP_IMM: begin
                case (funct3)
                    F3_ADD_SUB: aluop = EXE_ADDI_OP;
                    F3_SLL:     aluop = (funct7 == F7_BASE) ? EXE_SLLI_OP : EXE_NOP_OP;
                    F3_SLT:     aluop = EXE_SLTI_OP;
                    F3_SLTU:    aluop = EXE_SLTIU_OP;
                    F3_XOR:     aluop = EXE_XORI_OP;
                    F3_SRL:     aluop = (funct7 == F7_BASE) ? EXE_SRLI_OP : EXE_NOP_OP;
                    F3_OR:      aluop = EXE_ORI_OP;
                    default:    aluop = EXE_ANDI_OP;
                endcase
            end
            default: aluop = EXE_NOP_OP;
        endcase
        case (aluop)
            EXE_OR_OP, EXE_AND_OP, EXE_XOR_OP,
            EXE_ORI_OP, EXE_ANDI_OP, EXE_XORI_OP:      alusel = EXE_RES_LOGIC;
            EXE_SLL_OP, EXE_SLLI_OP, EXE_SRL_OP, EXE_SRLI_OP: alusel = EXE_RES_SHIFT;
            EXE_NOP_OP:                                 alusel = EXE_RES_NOP;
            default:                                    alusel = EXE_RES_ARITH;
        endcase
    end

    // The execute register holds the newest result not yet in the register file.
    assign reg1 = (fwd_valid_i && fwd_wreg_i && fwd_rd_i != '0 && fwd_rd_i == rs1) ?
                  fwd_data_i : rs1_data_i;
    assign reg2 = (fwd_valid_i && fwd_wreg_i && fwd_rd_i != '0 && fwd_rd_i == rs2) ?
                  fwd_data_i : rs2_data_i;

    // A source written by the instruction still in this register is not ready yet.
    assign hazard = ex_o.valid && ex_o.wreg && ex_o.rd != '0 &&
                    (ex_o.rd == rs1 || (opcode == OPC_OP && ex_o.rd == rs2));

    assign load         = !ex_o.valid || ex_o.ready;
    assign inst_ready_o = load && !hazard;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_o.valid  <= 1'b0;
            ex_o.aluop  <= EXE_NOP_OP;
            ex_o.alusel <= EXE_RES_NOP;
            ex_o.reg1   <= ZERO_WORD;
            ex_o.reg2   <= ZERO_WORD;
            ex_o.shamt  <= '0;
            ex_o.imm    <= ZERO_WORD;
            ex_o.rd     <= '0;
            ex_o.wreg   <= 1'b0;
        end else if (load) begin
            ex_o.valid  <= inst_valid_i && !hazard; // A stall inserts a bubble.
            ex_o.aluop  <= aluop;
            ex_o.alusel <= alusel;
            ex_o.reg1   <= reg1;
            ex_o.reg2   <= reg2;
            ex_o.shamt  <= shamt;
            ex_o.imm    <= imm;
            ex_o.rd     <= rd;
            ex_o.wreg   <= (aluop != EXE_NOP_OP);
        end
    end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  cpu_pkg::reg_addr_t raddr1_i,
    input  cpu_pkg::reg_addr_t raddr2_i,
    output cpu_pkg::word_t     rdata1_o,
    output cpu_pkg::word_t     rdata2_o,
    input  logic               we_i,
    input  cpu_pkg::reg_addr_t waddr_i,
    input  cpu_pkg::word_t     wdata_i
);
    import cpu_pkg::*;

    word_t regs_q [1:31]; // x0 has no storage.

    function automatic word_t read_port(reg_addr_t addr);
        word_t data;
        if (addr == '0) begin
            data = ZERO_WORD;
        end else if (we_i && waddr_i == addr) begin
            data = wdata_i; // Same-cycle write goes straight through.
        end else begin
            data = regs_q[addr];
        end
        return data;
    endfunction

    always_comb rdata1_o = read_port(raddr1_i);
    always_comb rdata2_o = read_port(raddr2_i);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= ZERO_WORD;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

endmodule

// File: logic/ex.sv
`timescale 1ns/10ps

module ex (
    input  logic               clk_i,
    input  logic               arst_n_i,
    exec_if.ex_mp              ex_i,
    output logic               res_valid_o,
    output cpu_pkg::reg_addr_t res_rd_o,
    output logic               res_wreg_o,
    output cpu_pkg::word_t     res_data_o,
    input  logic               res_ready_i
);
    import cpu_pkg::*;

    word_t logic_out;
    word_t shift_out;
    word_t arith_out;
    word_t result;
    logic  load;

    always_comb begin
        case (ex_i.aluop)
            EXE_OR_OP:   logic_out = ex_i.reg1 | ex_i.reg2;
            EXE_AND_OP:  logic_out = ex_i.reg1 & ex_i.reg2;
            EXE_XOR_OP:  logic_out = ex_i.reg1 ^ ex_i.reg2;
            EXE_ORI_OP:  logic_out = ex_i.reg1 | ex_i.imm;
            EXE_ANDI_OP: logic_out = ex_i.reg1 & ex_i.imm;
            EXE_XORI_OP: logic_out = ex_i.reg1 ^ ex_i.imm;
            default:     logic_out = ZERO_WORD;
        endcase
    end

    // Register shifts take the amount from the low five bits of rs2.
    always_comb begin
        case (ex_i.aluop)
            EXE_SLL_OP:  shift_out = ex_i.reg1 << ex_i.reg2[4:0];
            EXE_SLLI_OP: shift_out = ex_i.reg1 << ex_i.shamt;
            EXE_SRL_OP:  shift_out = ex_i.reg1 >> ex_i.reg2[4:0];
            EXE_SRLI_OP: shift_out = ex_i.reg1 >> ex_i.shamt;
            default:     shift_out = ZERO_WORD;
        endcase
    end

    always_comb begin
        case (ex_i.aluop)
            EXE_ADD_OP:   arith_out = ex_i.reg1 + ex_i.reg2;
            EXE_ADDI_OP:  arith_out = ex_i.reg1 + ex_i.imm;
            EXE_SUB_OP:   arith_out = ex_i.reg1 - ex_i.reg2;
            EXE_SLT_OP:   arith_out = word_t'($signed(ex_i.reg1) < $signed(ex_i.reg2));
            EXE_SLTI_OP:  arith_out = word_t'($signed(ex_i.reg1) < $signed(ex_i.imm));
            EXE_SLTU_OP:  arith_out = word_t'(ex_i.reg1 < ex_i.reg2);
            EXE_SLTIU_OP: arith_out = word_t'(ex_i.reg1 < ex_i.imm); // Sign-extended, then unsigned.
            default:      arith_out = ZERO_WORD;
        endcase
    end

    always_comb begin
        case (ex_i.alusel)
            EXE_RES_LOGIC: result = logic_out;
            EXE_RES_SHIFT: result = shift_out;
            EXE_RES_ARITH: result = arith_out;
            default:       result = ZERO_WORD;
        endcase
    end

    // The output register holds while the result port is busy.
    assign load       = !res_valid_o || res_ready_i;
    assign ex_i.ready = load;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            res_valid_o <= 1'b0;
            res_rd_o    <= '0;
            res_wreg_o  <= 1'b0;
            res_data_o  <= ZERO_WORD;
        end else if (load) begin
            res_valid_o <= ex_i.valid;
            res_rd_o    <= ex_i.rd;
            res_wreg_o  <= ex_i.wreg;
            res_data_o  <= result;
        end
    end

endmodule

// File: logic/result_port.sv
`timescale 1ns/10ps

module result_port (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               res_valid_i,
    input  cpu_pkg::reg_addr_t res_rd_i,
    input  logic               res_wreg_i,
    input  cpu_pkg::word_t     res_data_i,
    output logic               res_ready_o,
    output logic               we_o,
    output cpu_pkg::reg_addr_t waddr_o,
    output cpu_pkg::word_t     wdata_o,
    output logic               res_req_o,
    input  logic               res_ack_i,
    output cpu_pkg::reg_addr_t res_rd_o,
    output logic               res_wreg_o,
    output cpu_pkg::word_t     res_data_o
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_LOW
    } state_e;

    state_e state_q;
    logic   load;

    // A new result is taken once the previous ack has gone low.
    assign res_ready_o = (state_q == IDLE) || (state_q == WAIT_LOW && !res_ack_i);
    assign load        = res_valid_i && res_ready_o;
    assign res_req_o   = (state_q == REQ);

    assign we_o    = load && res_wreg_i && res_rd_i != '0; // Writeback in the load cycle.
    assign waddr_o = res_rd_i;
    assign wdata_o = res_data_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= IDLE;
            res_rd_o   <= '0;
            res_wreg_o <= 1'b0;
            res_data_o <= ZERO_WORD;
        end else begin
            if (load) begin
                res_rd_o   <= res_rd_i;
                res_wreg_o <= res_wreg_i;
                res_data_o <= res_data_i;
            end
            case (state_q)
                IDLE: if (load) state_q <= REQ;
                REQ:  if (res_ack_i) state_q <= WAIT_LOW;
                WAIT_LOW: begin
                    if (load) begin
                        state_q <= REQ;
                    end else if (!res_ack_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

// File: logic/alu_core_top.sv
`timescale 1ns/10ps

module alu_core_top (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               inst_req_i,
    input  cpu_pkg::inst_t     inst_i,
    output logic               inst_ack_o,
    output logic               res_req_o,
    input  logic               res_ack_i,
    output cpu_pkg::reg_addr_t res_rd_o,
    output logic               res_wreg_o,
    output cpu_pkg::word_t     res_data_o
);
    import cpu_pkg::*;

    logic      inst_valid;
    logic      inst_ready;
    inst_t     inst;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      res_valid;
    logic      res_ready;
    reg_addr_t res_rd;
    logic      res_wreg;
    word_t     res_data;
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;

    exec_if u_exec_if ();

    inst_port u_inst_port (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .inst_req_i   (inst_req_i),
        .inst_i       (inst_i),
        .inst_ack_o   (inst_ack_o),
        .inst_valid_o (inst_valid),
        .inst_o       (inst),
        .inst_ready_i (inst_ready)
    );

    // Forwarding taps the execute output register.
    decode u_decode (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (inst_valid),
        .inst_i       (inst),
        .inst_ready_o (inst_ready),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .fwd_valid_i  (res_valid),
        .fwd_wreg_i   (res_wreg),
        .fwd_rd_i     (res_rd),
        .fwd_data_i   (res_data),
        .ex_o         (u_exec_if.decode_mp)
    );

    reg_file u_reg_file (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data),
        .we_i     (we),
        .waddr_i  (waddr),
        .wdata_i  (wdata)
    );

    ex u_ex (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .ex_i        (u_exec_if.ex_mp),
        .res_valid_o (res_valid),
        .res_rd_o    (res_rd),
        .res_wreg_o  (res_wreg),
        .res_data_o  (res_data),
        .res_ready_i (res_ready)
    );

    result_port u_result_port (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .res_valid_i (res_valid),
        .res_rd_i    (res_rd),
        .res_wreg_i  (res_wreg),
        .res_data_i  (res_data),
        .res_ready_o (res_ready),
        .we_o        (we),
        .waddr_o     (waddr),
        .wdata_o     (wdata),
        .res_req_o   (res_req_o),
        .res_ack_i   (res_ack_i),
        .res_rd_o    (res_rd_o),
        .res_wreg_o  (res_wreg_o),
        .res_data_o  (res_data_o)
    );

endmodule

// File: test/tb_alu_core_table.svh
`ifndef TB_ALU_CORE_TABLE_SVH
`define TB_ALU_CORE_TABLE_SVH

localparam int NUM_ENTRIES = 28;

vector_t vectors [NUM_ENTRIES];

// Each row holds the instruction, the expected rd, write flag and data.
task automatic load_vectors();
    vectors[0]  = {32'h12300093, 5'd1,  1'b1, 32'h00000123}; // ADDI x1, x0, 0x123.
    vectors[1]  = {32'hFFF00113, 5'd2,  1'b1, 32'hFFFFFFFF}; // ADDI x2, x0, -1.
    vectors[2]  = {32'h7FF00193, 5'd3,  1'b1, 32'h000007FF};
    vectors[3]  = {32'h00208233, 5'd4,  1'b1, 32'h00000122}; // ADD x4, x1, x2 wraps.
    vectors[4]  = {32'h403082B3, 5'd5,  1'b1, 32'hFFFFF924}; // SUB x5, x1, x3.
    vectors[5]  = {32'h40110333, 5'd6,  1'b1, 32'hFFFFFEDC};
    vectors[6]  = {32'h002103B3, 5'd7,  1'b1, 32'hFFFFFFFE}; // ADD x7, x2, x2.
    // Logic group, register and immediate forms.
    vectors[7]  = {32'h0051F433, 5'd8,  1'b1, 32'h00000124}; // AND x8, x3, x5.
    vectors[8]  = {32'h0050E4B3, 5'd9,  1'b1, 32'hFFFFF927};
    vectors[9]  = {32'h0030C533, 5'd10, 1'b1, 32'h000006DC}; // XOR x10, x1, x3.
    vectors[10] = {32'hFF02F593, 5'd11, 1'b1, 32'hFFFFF920}; // ANDI x11, x5, -16.
    vectors[11] = {32'hF000E613, 5'd12, 1'b1, 32'hFFFFFF23}; // ORI x12, x1, -256.
    vectors[12] = {32'h5551C693, 5'd13, 1'b1, 32'h000002AA};
    // Shift amounts come from shamt or from the low five bits of rs2.
    vectors[13] = {32'h00409713, 5'd14, 1'b1, 32'h00001230}; // SLLI x14, x1, 4.
    vectors[14] = {32'h01C15793, 5'd15, 1'b1, 32'h0000000F}; // SRLI x15, x2, 28.
    vectors[15] = {32'h00609833, 5'd16, 1'b1, 32'h30000000}; // SLL x16, x1, x6.
    vectors[16] = {32'h00E2D8B3, 5'd17, 1'b1, 32'h0000FFFF}; // SRL x17, x5, x14.
    vectors[17] = {32'h0012A933, 5'd18, 1'b1, 32'h00000001}; // SLT x18, x5, x1.
    vectors[18] = {32'h0012B9B3, 5'd19, 1'b1, 32'h00000000};
    vectors[19] = {32'hFFF0AA13, 5'd20, 1'b1, 32'h00000000}; // SLTI x20, x1, -1.
    vectors[20] = {32'hFFF0BA93, 5'd21, 1'b1, 32'h00000001}; // SLTIU x21, x1, -1.
    // A dependent chain, each reading the result just before it.
    vectors[21] = {32'h00500B13, 5'd22, 1'b1, 32'h00000005};
    vectors[22] = {32'h016B0BB3, 5'd23, 1'b1, 32'h0000000A}; // ADD x23, x22, x22.
    vectors[23] = {32'h401B8C33, 5'd24, 1'b1, 32'hFFFFFEE7}; // SUB x24, x23, x1.
    vectors[24] = {32'h7FFC0C13, 5'd24, 1'b1, 32'h000006E6}; // ADDI x24, x24, 0x7FF.
    vectors[25] = {32'h01008013, 5'd0,  1'b1, 32'h00000133}; // ADDI x0, x1, 16.
    vectors[26] = {32'h00100CB3, 5'd25, 1'b1, 32'h00000123}; // ADD x25, x0, x1.
    vectors[27] = {32'h12345037, 5'd0,  1'b0, 32'h00000000}; // LUI is not supported.
endtask

`endif

// File: test/tb_alu_core.sv
`timescale 1ns/10ps

module tb_alu_core;
    import cpu_pkg::*;

    typedef struct packed {
        logic [31:0] inst;
        logic [4:0]  rd;
        logic        wreg;
        logic [31:0] data;
    } vector_t;

    `include "tb_alu_core_table.svh"

    logic      clk;
    logic      arst_n;
    logic      inst_req;
    inst_t     inst;
    logic      inst_ack;
    logic      res_req;
    logic      res_ack;
    reg_addr_t res_rd;
    logic      res_wreg;
    word_t     res_data;
    integer    seed;
    int        delay;
    int        errors;
    int        timeouts;
    int        res_count;
    logic      inst_ack_prev;
    logic      res_req_prev;
    reg_addr_t res_rd_prev;
    logic      res_wreg_prev;
    word_t     res_data_prev;

    alu_core_top u_dut (
        .clk_i      (clk),
        .arst_n_i   (arst_n),
        .inst_req_i (inst_req),
        .inst_i     (inst),
        .inst_ack_o (inst_ack),
        .res_req_o  (res_req),
        .res_ack_i  (res_ack),
        .res_rd_o   (res_rd),
        .res_wreg_o (res_wreg),
        .res_data_o (res_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // One full four-phase cycle on the input port.
    task automatic send_inst(input inst_t word);
        @(posedge clk);
        inst     <= word;
        inst_req <= 1'b1;
        do @(posedge clk); while (!inst_ack);
        inst_req <= 1'b0;
        do @(posedge clk); while (inst_ack);
    endtask

    task automatic check_result();
        vector_t exp;
        if (res_count >= NUM_ENTRIES) begin
            $display("an extra result came out at %0d ns with rd %0d", $time, res_rd);
            errors++;
        end else begin
            exp = vectors[res_count];
            assert (res_rd == exp.rd) else begin
                $display("error at %0d ns: entry %0d rd is %0d, expected %0d",
                         $time, res_count, res_rd, exp.rd);
                errors++;
            end
            assert (res_wreg == exp.wreg) else begin
                $display("error at %0d ns: entry %0d write flag is %0b, expected %0b",
                         $time, res_count, res_wreg, exp.wreg);
                errors++;
            end
            assert (res_data == exp.data) else begin
                $display("error at %0d ns: entry %0d data is %h, expected %h",
                         $time, res_count, res_data, exp.data);
                errors++;
            end
        end
        res_count++;
    endtask

    task automatic print_counts();
        $display("errors: %0d, timeouts: %0d, results: %0d of %0d",
                 errors, timeouts, res_count, NUM_ENTRIES);
    endtask

    initial begin
        arst_n    = 1'b0;
        inst_req  = 1'b0;
        inst      = '0;
        res_ack   = 1'b0;
        seed      = 79549;
        errors    = 0;
        timeouts  = 0;
        res_count = 0;
        load_vectors();
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            send_inst(vectors[i].inst);
        end
        wait (res_count == NUM_ENTRIES);
        repeat (20) @(posedge clk); // Leaves room for a duplicate to show up.
        print_counts();
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Consumer side of the output port, with a random ack delay.
    initial begin
        forever begin
            @(posedge clk);
            if (res_req && !res_ack) begin
                check_result();
                delay = $unsigned($random(seed)) % 6;
                repeat (delay) @(posedge clk);
                res_ack <= 1'b1;
                do @(posedge clk); while (res_req);
                res_ack <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (arst_n) begin
            assert (!(inst_ack && !inst_ack_prev) || inst_req) else begin
                $display("inst_ack_o rose at %0d ns while no request was pending", $time);
                errors++;
            end
            assert (!(!inst_ack && inst_ack_prev) || !inst_req) else begin
                $display("inst_ack_o fell at %0d ns while the request was still high", $time);
                errors++;
            end
            assert (!(res_req && !res_req_prev) || !res_ack) else begin
                $display("res_req_o rose at %0d ns before the last ack went low", $time);
                errors++;
            end
            assert (!(!res_req && res_req_prev) || res_ack) else begin
                $display("res_req_o fell at %0d ns without an ack", $time);
                errors++;
            end
            assert (!(res_req && res_req_prev) ||
                    (res_rd == res_rd_prev && res_wreg == res_wreg_prev &&
                     res_data == res_data_prev)) else begin
                $display("result outputs changed at %0d ns while res_req_o was high", $time);
                errors++;
            end
        end
        inst_ack_prev <= inst_ack;
        res_req_prev  <= res_req;
        res_rd_prev   <= res_rd;
        res_wreg_prev <= res_wreg;
        res_data_prev <= res_data;
    end

    initial begin
        repeat (NUM_ENTRIES * 20 + 50) @(posedge clk);
        timeouts++;
        $display("timeout: the run did not finish within %0d clock cycles",
                 NUM_ENTRIES * 20 + 50);
        print_counts();
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: all.f
+incdir+test
logic/cpu_pkg.sv
logic/exec_if.sv
logic/inst_port.sv
logic/decode.sv
logic/reg_file.sv
logic/ex.sv
logic/result_port.sv
logic/alu_core_top.sv
test/tb_alu_core.sv

// File: Bender.yml
package:
  name: alu_core

sources:
  - logic/cpu_pkg.sv
  - logic/exec_if.sv
  - logic/inst_port.sv
  - logic/decode.sv
  - logic/reg_file.sv
  - logic/ex.sv
  - logic/result_port.sv
  - logic/alu_core_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_alu_core.sv
